// File: hw/wb_pkg.sv
// --------------------------------------
// Writeback path package
// Widths, register count and ALU opcodes
// --------------------------------------

package wb_pkg;

  // Operand and result width
  localparam int data_bits = 32;

  // Sequence tag carried with every op
  localparam int seq_num_bits = 6;

  // Architectural register file shape
  localparam int reg_addr_bits = 5;
  localparam int num_regs = 32;

  // ALU opcodes
  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_pass
  } alu_op_e;

endpackage

// File: hw/x_w_if.sv
// --------------------------------------
// Execute to writeback interface
// One pipe's result with val/rdy handshake
// --------------------------------------

`timescale 1ns/1ps

interface x_w_if;
  import wb_pkg::*;

  // Result payload
  logic [seq_num_bits-1:0]  seq_num;
  logic [reg_addr_bits-1:0] waddr;
  logic [data_bits-1:0]     wdata;
  logic                     wen;

  // Handshake, transfer on val & rdy
  logic val;
  logic rdy;

  // Execute side
  modport ex (output seq_num, waddr, wdata, wen, val, input rdy);

  // Writeback side
  modport wb (input seq_num, waddr, wdata, wen, val, output rdy);

endinterface

// File: hw/complete_if.sv
// --------------------------------------
// Completion notification interface
// Strobe only, no back-pressure
// --------------------------------------

`timescale 1ns/1ps

interface complete_if;
  import wb_pkg::*;

  logic [seq_num_bits-1:0]  seq_num;
  logic [reg_addr_bits-1:0] waddr;
  logic [data_bits-1:0]     wdata;
  // One-cycle strobe per completion
  logic                     wen;

  // Writeback publishes
  modport pub (output seq_num, waddr, wdata, wen);

  // Register file subscribes
  modport sub (input seq_num, waddr, wdata, wen);

endinterface

// File: hw/alu_pipe.sv
// --------------------------------------
// Single-cycle ALU execute pipe
// Computes on issue, holds the result
// until writeback takes it
// --------------------------------------

`timescale 1ns/1ps

module alu_pipe (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             issue_val,
  output logic                             issue_rdy,
  input  wb_pkg::alu_op_e                  op,
  input  logic [wb_pkg::data_bits-1:0]     a,
  input  logic [wb_pkg::data_bits-1:0]     b,
  input  logic [wb_pkg::seq_num_bits-1:0]  seq,
  input  logic [wb_pkg::reg_addr_bits-1:0] waddr,
  input  logic                             wen,
  x_w_if.ex                                ex
);
  import wb_pkg::*;

  logic                 out_val;
  logic                 take;
  logic                 accept;
  logic [data_bits-1:0] result;

  // Output slot frees up when writeback grants us
  assign take      = out_val & ex.rdy;
  assign issue_rdy = ~out_val | ex.rdy;
  assign accept    = issue_val & issue_rdy;

  // ALU
  always_comb begin
    case (op)
      op_add:  result = a + b;
      op_sub:  result = a - b;
      op_and:  result = a & b;
      op_or:   result = a | b;
      op_xor:  result = a ^ b;
      // Shift amount from low 5 bits of b
      op_sll:  result = a << b[4:0];
      op_srl:  result = a >> b[4:0];
      op_pass: result = b;
      default: result = '0;
    endcase
  end

  // --------------------------------------
  // Output register
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      out_val <= 1'b0;
    end else if (accept) begin
      out_val <= 1'b1;
    end else if (take) begin
      out_val <= 1'b0;
    end
  end

  // Payload, only loaded on accept so it stays stable under stall
  always_ff @(posedge clk) begin
    if (accept) begin
      ex.seq_num <= seq;
      ex.waddr   <= waddr;
      ex.wdata   <= result;
      ex.wen     <= wen;
    end
  end

  assign ex.val = out_val;

endmodule

// File: hw/rr_arb.sv
// --------------------------------------
// Round-robin arbiter
// Pointer moves one past the last winner
// --------------------------------------

`timescale 1ns/1ps

module rr_arb #(
  parameter int num_pipes = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [num_pipes-1:0] req,
  output logic [num_pipes-1:0] gnt
);

  // At least one bit even for a single requester
  localparam int ptr_bits = (num_pipes > 1) ? $clog2(num_pipes) : 1;

  logic [ptr_bits-1:0] ptr;
  logic [ptr_bits-1:0] ptr_next;

  // First requester at or after ptr wins
  always_comb begin
    int  idx;
    logic found;
    gnt      = '0;
    ptr_next = ptr;
    found    = 1'b0;
    for (int k = 0; k < num_pipes; k++) begin
      idx = (int'(ptr) + k) % num_pipes;
      if (!found && req[idx]) begin
        found    = 1'b1;
        gnt[idx] = 1'b1;
        // Wrap past the last pipe
        ptr_next = (idx == num_pipes - 1) ? '0 : ptr_bits'(idx + 1);
      end
    end
  end

  // Reset favours pipe 0
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else begin
      ptr <= ptr_next;
    end
  end

endmodule

// File: hw/writeback.sv
// --------------------------------------
// Writeback unit
// Picks one pipe per cycle and registers
// its result as a completion
// --------------------------------------

`timescale 1ns/1ps

module writeback #(
  parameter int num_pipes = 2
) (
  input  logic     clk,
  input  logic     rst,
  x_w_if.wb        ex [num_pipes-1:0],
  complete_if.pub  complete
);
  import wb_pkg::*;

  // --------------------------------------
  // Arbitration
  // --------------------------------------

  logic [num_pipes-1:0] req;
  logic [num_pipes-1:0] gnt;

  // Masked per-pipe fields, zero unless granted
  logic [seq_num_bits-1:0]  seq_m   [num_pipes];
  logic [reg_addr_bits-1:0] waddr_m [num_pipes];
  logic [data_bits-1:0]     wdata_m [num_pipes];
  logic [num_pipes-1:0]     wen_m;

  for (genvar i = 0; i < num_pipes; i++) begin : g_pipe
    assign req[i]   = ex[i].val;
    // Grant doubles as ready
    assign ex[i].rdy = gnt[i];

    assign seq_m[i]   = ex[i].seq_num & {seq_num_bits{gnt[i]}};
    assign waddr_m[i] = ex[i].waddr & {reg_addr_bits{gnt[i]}};
    assign wdata_m[i] = ex[i].wdata & {data_bits{gnt[i]}};
    assign wen_m[i]   = ex[i].wen & gnt[i];
  end

  rr_arb #(
    .num_pipes(num_pipes)
  ) u_arb (
    .clk(clk),
    .rst(rst),
    .req(req),
    .gnt(gnt)
  );

  // --------------------------------------
  // AND-OR select of the granted pipe
  // --------------------------------------

  logic [seq_num_bits-1:0]  sel_seq;
  logic [reg_addr_bits-1:0] sel_waddr;
  logic [data_bits-1:0]     sel_wdata;
  logic                     sel_val;

  always_comb begin
    sel_seq   = '0;
    sel_waddr = '0;
    sel_wdata = '0;
    for (int k = 0; k < num_pipes; k++) begin
      sel_seq   = sel_seq | seq_m[k];
      sel_waddr = sel_waddr | waddr_m[k];
      sel_wdata = sel_wdata | wdata_m[k];
    end
  end

  assign sel_val = |gnt;

  // --------------------------------------
  // Completion register
  // --------------------------------------

  // Strobe low when nothing was transferred
  always_ff @(posedge clk) begin
    if (rst) begin
      complete.wen <= 1'b0;
    end else begin
      complete.wen <= sel_val & (|wen_m);
    end
  end

  // Payload kept from the last transfer
  always_ff @(posedge clk) begin
    if (sel_val) begin
      complete.seq_num <= sel_seq;
      complete.waddr   <= sel_waddr;
      complete.wdata   <= sel_wdata;
    end
  end

endmodule

// File: hw/reg_file.sv
// --------------------------------------
// Architectural register file
// Written by completions, x0 reads zero
// --------------------------------------

`timescale 1ns/1ps

module reg_file (
  input  logic                             clk,
  input  logic                             rst,
  complete_if.sub                          complete,
  input  logic [wb_pkg::reg_addr_bits-1:0] rd_addr0,
  input  logic [wb_pkg::reg_addr_bits-1:0] rd_addr1,
  output logic [wb_pkg::data_bits-1:0]     rd_data0,
  output logic [wb_pkg::data_bits-1:0]     rd_data1
);
  import wb_pkg::*;

  logic [data_bits-1:0] regs [num_regs];

  // Write on the completion strobe, x0 never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < num_regs; k++) begin
        regs[k] <= '0;
      end
    end else if (complete.wen && complete.waddr != '0) begin
      regs[complete.waddr] <= complete.wdata;
    end
  end

  // Combinational read ports
  assign rd_data0 = (rd_addr0 == '0) ? '0 : regs[rd_addr0];
  assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];

endmodule

// File: hw/wb_top.sv
// --------------------------------------
// Writeback path top level
// Execute pipes, writeback, register file
// --------------------------------------

`timescale 1ns/1ps

module wb_top #(
  parameter int num_pipes = 2
) (
  input  logic                                            clk,
  input  logic                                            rst,
  // Issue side, one lane per pipe
  input  logic [num_pipes-1:0]                            issue_val,
  output logic [num_pipes-1:0]                            issue_rdy,
  input  wb_pkg::alu_op_e [num_pipes-1:0]                 issue_op,
  input  logic [num_pipes-1:0][wb_pkg::data_bits-1:0]     issue_a,
  input  logic [num_pipes-1:0][wb_pkg::data_bits-1:0]     issue_b,
  input  logic [num_pipes-1:0][wb_pkg::seq_num_bits-1:0]  issue_seq,
  input  logic [num_pipes-1:0][wb_pkg::reg_addr_bits-1:0] issue_waddr,
  input  logic [num_pipes-1:0]                            issue_wen,
  // Completion strobe
  output logic                                            cmpl_wen,
  output logic [wb_pkg::seq_num_bits-1:0]                 cmpl_seq,
  output logic [wb_pkg::reg_addr_bits-1:0]                cmpl_waddr,
  output logic [wb_pkg::data_bits-1:0]                    cmpl_wdata,
  // Register read ports
  input  logic [wb_pkg::reg_addr_bits-1:0]                rd_addr0,
  output logic [wb_pkg::data_bits-1:0]                    rd_data0,
  input  logic [wb_pkg::reg_addr_bits-1:0]                rd_addr1,
  output logic [wb_pkg::data_bits-1:0]                    rd_data1
);

  x_w_if      x_w [num_pipes-1:0] ();
  complete_if cmpl ();

  // --------------------------------------
  // Execute pipes
  // --------------------------------------

  for (genvar i = 0; i < num_pipes; i++) begin : g_pipe
    alu_pipe u_pipe (
      .clk      (clk),
      .rst      (rst),
      .issue_val(issue_val[i]),
      .issue_rdy(issue_rdy[i]),
      .op       (issue_op[i]),
      .a        (issue_a[i]),
      .b        (issue_b[i]),
      .seq      (issue_seq[i]),
      .waddr    (issue_waddr[i]),
      .wen      (issue_wen[i]),
      .ex       (x_w[i])
    );
  end

  writeback #(
    .num_pipes(num_pipes)
  ) u_wb (
    .clk     (clk),
    .rst     (rst),
    .ex      (x_w),
    .complete(cmpl)
  );

  reg_file u_rf (
    .clk     (clk),
    .rst     (rst),
    .complete(cmpl),
    .rd_addr0(rd_addr0),
    .rd_addr1(rd_addr1),
    .rd_data0(rd_data0),
    .rd_data1(rd_data1)
  );

  // Completion outputs straight from the register
  assign cmpl_wen   = cmpl.wen;
  assign cmpl_seq   = cmpl.seq_num;
  assign cmpl_waddr = cmpl.waddr;
  assign cmpl_wdata = cmpl.wdata;

endmodule

// File: test/wb_chk.sv
// ----------------------------------------
// Writeback unit assertions
// Grant shape, fairness, completion strobe
// ----------------------------------------

`timescale 1ns/1ps

module wb_chk #(
  parameter int num_pipes = 2
) (
  input logic                 clk,
  input logic                 rst,
  input logic [num_pipes-1:0] req,
  input logic [num_pipes-1:0] gnt,
  input logic                 cmpl_wen
);

  // Cycles each pipe has waited with a valid result
  int wait_cnt [num_pipes];

  always_ff @(posedge clk) begin
    for (int k = 0; k < num_pipes; k++) begin
      if (rst || !req[k] || gnt[k]) begin
        wait_cnt[k] <= 0;
      end else begin
        wait_cnt[k] <= wait_cnt[k] + 1;
      end
    end
  end

  // At most one winner
  a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
    else $error("grant is not one-hot");

  // Winner must hold a valid result
  a_gnt_valid: assert property (@(posedge clk) disable iff (rst) (gnt & ~req) == '0)
    else $error("grant to a pipe without a valid result");

  // Strobe only follows a transfer
  a_wen_after_xfer: assert property (@(posedge clk) disable iff (rst) cmpl_wen |-> $past(|gnt))
    else $error("completion strobe without a transfer the cycle before");

  for (genvar i = 0; i < num_pipes; i++) begin : g_fair
    a_wait_bound: assert property (@(posedge clk) disable iff (rst) wait_cnt[i] < num_pipes)
      else $error("pipe waited too long for a grant");
  end

endmodule

bind writeback wb_chk #(
  .num_pipes(num_pipes)
) u_chk (
  .clk     (clk),
  .rst     (rst),
  .req     (req),
  .gnt     (gnt),
  .cmpl_wen(complete.wen)
);

// File: test/tb_wb_top.sv
// ----------------------------------------
// Writeback path testbench
// Random issue traffic checked against
// per-pipe queues and a register model
// ----------------------------------------

`timescale 1ns/1ps

module tb_wb_top;
  import wb_pkg::*;

  localparam int num_pipes    = 2;
  localparam int reset_cycles = 8;
  localparam int num_ops      = 400;
  // Four cycles per op plus slack for reset and drain
  localparam int max_cycles   = 4 * num_ops + 100;

  // One expected completion
  typedef struct packed {
    logic [seq_num_bits-1:0]  seq;
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     data;
  } exp_t;

  logic                                   clk = 1'b0;
  logic                                   rst;
  logic [num_pipes-1:0]                   issue_val;
  logic [num_pipes-1:0]                   issue_rdy;
  alu_op_e [num_pipes-1:0]                issue_op;
  logic [num_pipes-1:0][data_bits-1:0]    issue_a;
  logic [num_pipes-1:0][data_bits-1:0]    issue_b;
  logic [num_pipes-1:0][seq_num_bits-1:0] issue_seq;
  logic [num_pipes-1:0][reg_addr_bits-1:0] issue_waddr;
  logic [num_pipes-1:0]                   issue_wen;
  logic                                   cmpl_wen;
  logic [seq_num_bits-1:0]                cmpl_seq;
  logic [reg_addr_bits-1:0]               cmpl_waddr;
  logic [data_bits-1:0]                   cmpl_wdata;
  logic [reg_addr_bits-1:0]               rd_addr0;
  logic [reg_addr_bits-1:0]               rd_addr1;
  logic [data_bits-1:0]                   rd_data0;
  logic [data_bits-1:0]                   rd_data1;

  // ----------------------------------------
  // Model state
  // ----------------------------------------

  logic [31:0]              rng_state = 32'h2243_f080;
  exp_t                     exp_q [num_pipes][$];
  logic [data_bits-1:0]     model_regs [num_regs];
  logic [seq_num_bits-1:0]  seq_cnt [num_pipes];
  bit                       op_seen [8];
  // Strobe seen last cycle lands in the model one edge later
  logic                     wr_pending = 1'b0;
  logic [reg_addr_bits-1:0] wr_addr;
  logic [data_bits-1:0]     wr_data;
  int                       issued = 0;
  int                       cycle_cnt = 0;

  wb_top #(
    .num_pipes(num_pipes)
  ) dut (
    .clk(clk), .rst(rst),
    .issue_val(issue_val), .issue_rdy(issue_rdy), .issue_op(issue_op),
    .issue_a(issue_a), .issue_b(issue_b), .issue_seq(issue_seq),
    .issue_waddr(issue_waddr), .issue_wen(issue_wen),
    .cmpl_wen(cmpl_wen), .cmpl_seq(cmpl_seq),
    .cmpl_waddr(cmpl_waddr), .cmpl_wdata(cmpl_wdata),
    .rd_addr0(rd_addr0), .rd_data0(rd_data0),
    .rd_addr1(rd_addr1), .rd_data1(rd_data1)
  );

  always #2 clk = ~clk;

  // Cycle limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      fail_run("timeout, the run went past its cycle limit");
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Opcode rules
  function automatic logic [31:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_sll:  return a << b[4:0];
      op_srl:  return a >> b[4:0];
      default: return b;
    endcase
  endfunction

  function automatic int pending_ops();
    int n;
    n = 0;
    for (int p = 0; p < num_pipes; p++) begin
      n += exp_q[p].size();
    end
    return n;
  endfunction

  function automatic bit all_ops_seen();
    bit ok;
    ok = 1'b1;
    for (int k = 0; k < 8; k++) begin
      ok &= op_seen[k];
    end
    return ok;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      fail_run("a checked value differs from the model");
    end
  endtask

  // Both read ports against the model
  // x0 stays zero in the model
  task automatic check_reads();
    compare_value("rd_data0", rd_data0, model_regs[rd_addr0]);
    compare_value("rd_data1", rd_data1, model_regs[rd_addr1]);
  endtask

  task automatic drive_reads();
    logic [31:0] r;
    r        = next_rand();
    rd_addr0 = r[4:0];
    rd_addr1 = r[9:5];
  endtask

  // New issue lanes
  // issue_rdy depends on registered state only
  // and already shows whether the next edge accepts
  task automatic drive_issues(input bit issuing);
    logic [31:0] r;
    exp_t        e;
    for (int p = 0; p < num_pipes; p++) begin
      r              = next_rand();
      issue_val[p]   = issuing && (r[1:0] != 2'b00);
      issue_op[p]    = alu_op_e'(r[4:2]);
      issue_waddr[p] = r[9:5];
      issue_wen[p]   = (r[12:10] != 3'b000);
      issue_seq[p]   = seq_cnt[p];
      issue_a[p]     = next_rand();
      issue_b[p]     = next_rand();
      if (issue_val[p] && issue_rdy[p]) begin
        issued++;
        seq_cnt[p]      = seq_cnt[p] + seq_num_bits'(num_pipes);
        // Ops with wen low never raise the strobe
        if (issue_wen[p]) begin
          op_seen[r[4:2]] = 1'b1;
          e.seq   = issue_seq[p];
          e.waddr = issue_waddr[p];
          e.data  = alu_model(issue_op[p], issue_a[p], issue_b[p]);
          exp_q[p].push_back(e);
        end
      end
    end
  endtask

  // Reset state checks
  task automatic idle_cycle();
    @(negedge clk);
    compare_value("cmpl_wen", 32'(cmpl_wen), 32'(1'b0));
    compare_value("issue_rdy", 32'(issue_rdy), 32'({num_pipes{1'b1}}));
    check_reads();
    drive_reads();
  endtask

  task automatic step_cycle(input bit issuing);
    exp_t e;
    int   p;
    @(negedge clk);
    if (wr_pending && wr_addr != '0) begin
      model_regs[wr_addr] = wr_data;
    end
    wr_pending = 1'b0;
    check_reads();
    if (cmpl_wen) begin
      // Tag parity names the pipe
      p = int'(cmpl_seq[0]);
      if (exp_q[p].size() == 0) begin
        fail_run("completion strobe with no operation outstanding on its pipe");
      end else begin
        e = exp_q[p].pop_front();
        compare_value("cmpl_seq", 32'(cmpl_seq), 32'(e.seq));
        compare_value("cmpl_waddr", 32'(cmpl_waddr), 32'(e.waddr));
        compare_value("cmpl_wdata", cmpl_wdata, e.data);
        wr_pending = 1'b1;
        wr_addr    = e.waddr;
        wr_data    = e.data;
      end
    end
    drive_issues(issuing);
    drive_reads();
  endtask

  initial begin
    rst         = 1'b1;
    issue_val   = '0;
    issue_a     = '0;
    issue_b     = '0;
    issue_seq   = '0;
    issue_waddr = '0;
    issue_wen   = '0;
    rd_addr0    = '0;
    rd_addr1    = '0;
    for (int p = 0; p < num_pipes; p++) begin
      issue_op[p] = op_add;
      seq_cnt[p]  = seq_num_bits'(p);
    end
    for (int k = 0; k < num_regs; k++) begin
      model_regs[k] = '0;
    end
    for (int k = 0; k < reset_cycles; k++) begin
      idle_cycle();
    end
    rst = 1'b0;
    // First cycle out of reset
    idle_cycle();
    while (issued < num_ops) begin
      step_cycle(1'b1);
    end
    while (pending_ops() != 0) begin
      step_cycle(1'b0);
    end
    // Last strobe reaches the register file one edge later
    step_cycle(1'b0);
    step_cycle(1'b0);
    if (!all_ops_seen()) begin
      fail_run("not every opcode was checked on a completion during the run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: filelist.f
hw/wb_pkg.sv
hw/x_w_if.sv
hw/complete_if.sv
hw/alu_pipe.sv
hw/rr_arb.sv
hw/writeback.sv
hw/reg_file.sv
hw/wb_top.sv
test/wb_chk.sv
test/tb_wb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the writeback path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_wb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_wb_top 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
echo "pass message not found in the output"
exit 1
